// File: hl2_cmd.f
hdl/hl2_cfg_pkg.sv
hdl/hl2_cmd_pkg.sv
hdl/cmd_decode.sv
hdl/cmd_execute.sv
hdl/cmd_response.sv
hdl/hl2_cmd_top.sv
dv/hl2_cmd_chk.sv
dv/hl2_cmd_tb.sv

// File: Makefile
# Verilator build and run of the command path testbench

TOP   := hl2_cmd_tb
BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir $(BUILD) -f hl2_cmd.f
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// File: dv/hl2_cmd_tb.sv
// Command path testbench
// Runs a table of Wishbone writes, reads, local MAC and TX keying
// checks against the command path top level.

module hl2_cmd_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import hl2_cfg_pkg::*;
  import hl2_cmd_pkg::*;

  localparam mac_t       TB_BASE_MAC = DEFAULT_BASE_MAC;
  localparam logic [7:0] TB_VERSION  = 8'd72;

  typedef enum logic [1:0] {ST_WRITE, ST_READ, ST_MAC, ST_TXON} step_e;

  // one table row, expected holds a word, a MAC or tx_on in bit 0
  typedef struct packed {
    step_e     kind;
    cmd_addr_t adr;
    cmd_word_t data;
    logic      inhibit;
    logic      alt_pin;
    mac_t      expected;
  } step_t;

  logic      clk_ctrl;
  logic      rst_n_i;
  logic      wb_cyc_i;
  logic      wb_stb_i;
  logic      wb_we_i;
  cmd_addr_t wb_adr_i;
  cmd_word_t wb_dat_i;
  cmd_word_t wb_dat_o;
  logic      wb_ack_o;
  logic      alternate_mac_i;
  logic      tx_inhibit_i;
  mac_t      local_mac_o;
  logic      tx_on_o;

  step_t steps[$];
  int    cycles = 0;
  int    cycle_limit = 0;

  hl2_cmd_top #(
    .BASE_MAC      (TB_BASE_MAC),
    .VERSION_MAJOR (TB_VERSION)
  ) DUT (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .alternate_mac_i (alternate_mac_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .local_mac_o     (local_mac_o),
    .tx_on_o         (tx_on_o)
  );

  ////////////////////////////////////////
  // clock and timeout
  ////////////////////////////////////////

  initial begin
    clk_ctrl = 1'b0;
    forever #10 clk_ctrl = ~clk_ctrl;
  end

  always @(posedge clk_ctrl) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, DUT stopped answering", cycles));
    end
  end

  ////////////////////////////////////////
  // error exit and compares
  ////////////////////////////////////////

  task automatic abort_run(string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(string name, cmd_word_t got, cmd_word_t expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected));
    end
  endtask

  task automatic check_mac(string name, mac_t got, mac_t expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected));
    end
  endtask

  task automatic check_bit(string name, logic got, logic expected);
    if (got !== expected) begin
      abort_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, got, expected));
    end
  endtask

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  // pin selects the factory address, bit 1 is the inverted pin
  function automatic mac_t pin_mac(logic alt_pin);
    return {TB_BASE_MAC[47:2], ~alt_pin, TB_BASE_MAC[0]};
  endfunction

  function automatic mac_t stored_mac(logic [15:0] low_half);
    return {TB_BASE_MAC[47:16], low_half};
  endfunction

  function automatic void add_step(step_e kind, cmd_addr_t adr, cmd_word_t data,
                                   logic inhibit, logic alt_pin, mac_t expected);
    step_t s;
    s.kind     = kind;
    s.adr      = adr;
    s.data     = data;
    s.inhibit  = inhibit;
    s.alt_pin  = alt_pin;
    s.expected = expected;
    steps.push_back(s);
  endfunction

  task automatic build_table();
    cmd_word_t ip_val;
    cmd_word_t mac_val;
    cmd_word_t junk_val;
    ip_val   = $urandom();
    mac_val  = $urandom();
    junk_val = $urandom();
    // everything reads zero out of reset
    add_step(ST_READ,  ADDR_STATIC_IP,  '0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_ALT_MAC,    '0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_EEPROM_CFG, '0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_TXCTRL,     '0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_STATUS,     '0, 1'b0, 1'b0, '0);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b0, 1'b0, '0);
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b0, pin_mac(1'b0));
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b1, pin_mac(1'b1));
    // stored network settings
    add_step(ST_WRITE, ADDR_STATIC_IP,  ip_val, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_STATIC_IP,  '0, 1'b0, 1'b0, {16'h0, ip_val});
    add_step(ST_WRITE, ADDR_ALT_MAC,    mac_val, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_ALT_MAC,    '0, 1'b0, 1'b0, {32'h0, mac_val[15:0]});
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b1, pin_mac(1'b1));
    // bit 6 set switches to the stored low half
    add_step(ST_WRITE, ADDR_EEPROM_CFG, 32'h0000_a5c0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_EEPROM_CFG, '0, 1'b0, 1'b0, 48'hc0);
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b0, stored_mac(mac_val[15:0]));
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b1, stored_mac(mac_val[15:0]));
    add_step(ST_WRITE, ADDR_EEPROM_CFG, 32'h0000_00bf, 1'b0, 1'b0, '0);
    add_step(ST_MAC,   ADDR_STATUS,     '0, 1'b0, 1'b0, pin_mac(1'b0));
    // version is read only, unknown words read zero
    add_step(ST_READ,  ADDR_VERSION,    '0, 1'b0, 1'b0, {40'h0, TB_VERSION});
    add_step(ST_WRITE, ADDR_VERSION,    junk_val, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_VERSION,    '0, 1'b0, 1'b0, {40'h0, TB_VERSION});
    add_step(ST_WRITE, 6'h15,           junk_val, 1'b0, 1'b0, '0);
    add_step(ST_READ,  6'h15,           '0, 1'b0, 1'b0, '0);
    add_step(ST_READ,  ADDR_STATIC_IP,  '0, 1'b0, 1'b0, {16'h0, ip_val});
    // TX keying needs both mox and PA enable
    add_step(ST_WRITE, ADDR_TXCTRL,     32'h1, 1'b0, 1'b0, '0);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b0, 1'b0, '0);
    add_step(ST_WRITE, ADDR_TXCTRL,     32'h3, 1'b0, 1'b0, '0);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b0, 1'b0, 48'h1);
    add_step(ST_READ,  ADDR_TXCTRL,     '0, 1'b0, 1'b0, 48'h3);
    add_step(ST_READ,  ADDR_STATUS,     '0, 1'b0, 1'b0, 48'h1);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b1, 1'b0, '0);
    add_step(ST_READ,  ADDR_STATUS,     '0, 1'b1, 1'b0, 48'h2);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b0, 1'b0, 48'h1);
    add_step(ST_WRITE, ADDR_TXCTRL,     32'h0, 1'b0, 1'b0, '0);
    add_step(ST_TXON,  ADDR_STATUS,     '0, 1'b0, 1'b0, '0);
  endtask

  ////////////////////////////////////////
  // bus tasks
  ////////////////////////////////////////

  task automatic wait_ack();
    @(negedge clk_ctrl);
    while (wb_ack_o !== 1'b1) begin
      @(negedge clk_ctrl);
    end
  endtask

  // hold the request over the ack edge, ack must be gone by then
  task automatic end_cycle();
    @(negedge clk_ctrl);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic bus_write(cmd_addr_t adr, cmd_word_t data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b1;
    wb_adr_i = adr;
    wb_dat_i = data;
    wait_ack();
    // a write returns an empty word
    check_word("wb_dat_o", wb_dat_o, '0);
    end_cycle();
  endtask

  task automatic bus_read(cmd_addr_t adr, output cmd_word_t data);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = adr;
    wait_ack();
    data = wb_dat_o;
    end_cycle();
  endtask

  task automatic run_step(step_t s);
    cmd_word_t rd_data;
    @(negedge clk_ctrl);
    // the last transfer must not be acked twice
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    tx_inhibit_i    = s.inhibit;
    alternate_mac_i = s.alt_pin;
    case (s.kind)
      ST_WRITE: begin
        bus_write(s.adr, s.data);
      end
      ST_READ: begin
        bus_read(s.adr, rd_data);
        check_word("wb_dat_o", rd_data, s.expected[31:0]);
      end
      ST_MAC: begin
        @(negedge clk_ctrl);
        check_mac("local_mac_o", local_mac_o, s.expected);
      end
      default: begin
        @(negedge clk_ctrl);
        check_bit("tx_on_o", tx_on_o, s.expected[0]);
      end
    endcase
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    rst_n_i         = 1'b0;
    wb_cyc_i        = 1'b0;
    wb_stb_i        = 1'b0;
    wb_we_i         = 1'b0;
    wb_adr_i        = '0;
    wb_dat_i        = '0;
    alternate_mac_i = 1'b0;
    tx_inhibit_i    = 1'b0;
    void'($urandom(72));
    build_table();
    cycle_limit = 10 + 8 * steps.size() + 50;
    repeat (10) @(negedge clk_ctrl);
    rst_n_i = 1'b1;
    @(negedge clk_ctrl);
    check_bit("wb_ack_o", wb_ack_o, 1'b0);
    check_bit("tx_on_o", tx_on_o, 1'b0);
    check_word("wb_dat_o", wb_dat_o, '0);
    foreach (steps[i]) begin
      run_step(steps[i]);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: dv/hl2_cmd_chk.sv
// Command path assertions
// Bus handshake and TX keying properties, bound into the decoder and
// the register block.

module hl2_cmd_chk #(
  parameter bit CHECK_BUS = 1'b1,
  parameter bit CHECK_TX  = 1'b1
) (
  input logic clk_i,
  input logic rst_n_i,
  input logic cyc_i,
  input logic stb_i,
  input logic ack_i,
  input logic tx_inhibit_i,
  input logic tx_on_i
);

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  if (CHECK_BUS) begin : g_bus
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |-> (cyc_i && stb_i))
      else $error("ack without an active cycle and strobe");

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ack_i |=> !ack_i)
      else $error("ack held for two cycles");

    // no disable here, reset is the trigger
    ack_low_after_reset: assert property (@(posedge clk_i)
      !rst_n_i |=> !ack_i)
      else $error("ack high in the cycle after reset");
  end

  ////////////////////////////////////////
  // TX keying
  ////////////////////////////////////////

  if (CHECK_TX) begin : g_tx
    inhibit_drops_tx: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_inhibit_i |=> !tx_on_i)
      else $error("tx_on high one cycle after inhibit");
  end

endmodule

// decoder sees the bus only
bind cmd_decode hl2_cmd_chk #(
  .CHECK_BUS (1'b1),
  .CHECK_TX  (1'b0)
) u_bus_chk (
  .clk_i        (clk_ctrl),
  .rst_n_i      (rst_n_i),
  .cyc_i        (wb_cyc_i),
  .stb_i        (wb_stb_i),
  .ack_i        (wb_ack_o),
  .tx_inhibit_i (1'b0),
  .tx_on_i      (1'b0)
);

// register block sees the keying only
bind cmd_execute hl2_cmd_chk #(
  .CHECK_BUS (1'b0),
  .CHECK_TX  (1'b1)
) u_tx_chk (
  .clk_i        (clk_ctrl),
  .rst_n_i      (rst_n_i),
  .cyc_i        (1'b0),
  .stb_i        (1'b0),
  .ack_i        (1'b0),
  .tx_inhibit_i (tx_inhibit_i),
  .tx_on_i      (tx_on_q)
);

// File: hdl/hl2_cmd_top.sv
// Command path top level
// Wishbone classic slave for host commands: decode, configuration
// register execute and readback, all in the clk_ctrl domain.

module hl2_cmd_top #(
  parameter hl2_cmd_pkg::mac_t BASE_MAC      = hl2_cfg_pkg::DEFAULT_BASE_MAC,
  parameter logic [7:0]        VERSION_MAJOR = 8'd72
) (
  input  logic                   clk_ctrl,
  input  logic                   rst_n_i,
  // Wishbone classic slave
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  hl2_cmd_pkg::cmd_addr_t wb_adr_i,
  input  hl2_cmd_pkg::cmd_word_t wb_dat_i,
  output hl2_cmd_pkg::cmd_word_t wb_dat_o,
  output logic                   wb_ack_o,
  // board inputs
  input  logic                   alternate_mac_i,
  input  logic                   tx_inhibit_i,
  // status outputs
  output hl2_cmd_pkg::mac_t      local_mac_o,
  output logic                   tx_on_o
);

  import hl2_cmd_pkg::*;

  cmd_req_t  req;
  cfg_regs_t regs;

  ////////////////////////////////////////
  // command blocks
  ////////////////////////////////////////

  cmd_decode u_decode (
    .clk_ctrl (clk_ctrl),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_ack_o (wb_ack_o),
    .req_o    (req)
  );

  cmd_execute #(
    .BASE_MAC (BASE_MAC)
  ) u_execute (
    .clk_ctrl        (clk_ctrl),
    .rst_n_i         (rst_n_i),
    .req_i           (req),
    .alternate_mac_i (alternate_mac_i),
    .tx_inhibit_i    (tx_inhibit_i),
    .regs_o          (regs),
    .local_mac_o     (local_mac_o)
  );

  cmd_response #(
    .VERSION_MAJOR (VERSION_MAJOR)
  ) u_response (
    .clk_ctrl     (clk_ctrl),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .regs_i       (regs),
    .tx_inhibit_i (tx_inhibit_i),
    .wb_dat_o     (wb_dat_o)
  );

  // keying comes straight from the register block
  assign tx_on_o = regs.tx_on;

endmodule

// File: hdl/cmd_response.sv
// Command response
// Forms the readback word for a Wishbone read from the register view,
// the firmware version and the TX status, and holds it between transfers.

module cmd_response #(
  parameter logic [7:0] VERSION_MAJOR = 8'd72
) (
  input  logic                   clk_ctrl,
  input  logic                   rst_n_i,
  input  hl2_cmd_pkg::cmd_req_t  req_i,
  input  hl2_cmd_pkg::cfg_regs_t regs_i,
  input  logic                   tx_inhibit_i,
  output hl2_cmd_pkg::cmd_word_t wb_dat_o
);

  import hl2_cmd_pkg::*;

  cmd_word_t rd_word;
  cmd_word_t rd_q;

  ////////////////////////////////////////
  // readback word
  ////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    case (req_i.op)
      OP_TXCTRL: begin
        rd_word[1:0] = {regs_i.pa_en, regs_i.mox};
      end
      OP_STATIC_IP: begin
        rd_word = regs_i.static_ip;
      end
      OP_ALT_MAC: begin
        rd_word[15:0] = regs_i.alt_mac;
      end
      OP_EEPROM_CFG: begin
        rd_word[7:0] = regs_i.eeprom_cfg;
      end
      OP_VERSION: begin
        rd_word[7:0] = VERSION_MAJOR;
      end
      // live keying state and the inhibit pin
      OP_STATUS: begin
        rd_word[1:0] = {tx_inhibit_i, regs_i.tx_on};
      end
      default: begin
        rd_word = '0;
      end
    endcase
    // writes return nothing
    if (req_i.we) begin
      rd_word = '0;
    end
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      rd_q <= '0;
    end else if (req_i.valid) begin
      rd_q <= rd_word;
    end
  end

  // new word during ack, last word otherwise
  assign wb_dat_o = req_i.valid ? rd_word : rd_q;

endmodule

// File: hdl/cmd_execute.sv
// Command execute
// Holds the configuration registers written by host commands, keys the
// transmitter from mox, PA enable and the inhibit input, and selects the
// local MAC address.

module cmd_execute #(
  parameter hl2_cmd_pkg::mac_t BASE_MAC = hl2_cfg_pkg::DEFAULT_BASE_MAC
) (
  input  logic                   clk_ctrl,
  input  logic                   rst_n_i,
  input  hl2_cmd_pkg::cmd_req_t  req_i,
  input  logic                   alternate_mac_i,
  input  logic                   tx_inhibit_i,
  output hl2_cmd_pkg::cfg_regs_t regs_o,
  output hl2_cmd_pkg::mac_t      local_mac_o
);

  import hl2_cfg_pkg::*;
  import hl2_cmd_pkg::*;

  cmd_word_t   static_ip_q;
  logic [15:0] alt_mac_q;
  logic [7:0]  eeprom_cfg_q;
  logic        mox_q;
  logic        pa_en_q;
  logic        tx_on_q;
  logic        wr_en;

  assign wr_en = req_i.valid && req_i.we;

  ////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      static_ip_q  <= '0;
      alt_mac_q    <= '0;
      eeprom_cfg_q <= '0;
      mox_q        <= 1'b0;
      pa_en_q      <= 1'b0;
    end else if (wr_en) begin
      case (req_i.op)
        OP_TXCTRL: begin
          mox_q   <= req_i.data[0];
          pa_en_q <= req_i.data[1];
        end
        OP_STATIC_IP: begin
          static_ip_q <= req_i.data;
        end
        // only the low half of the MAC is stored
        OP_ALT_MAC: begin
          alt_mac_q <= req_i.data[15:0];
        end
        OP_EEPROM_CFG: begin
          eeprom_cfg_q <= req_i.data[7:0];
        end
        // version, status and unknown words are read only
        default: begin
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // TX keying
  ////////////////////////////////////////

  // inhibit wins over a keyed transmitter
  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      tx_on_q <= 1'b0;
    end else begin
      tx_on_q <= mox_q & pa_en_q & ~tx_inhibit_i;
    end
  end

  ////////////////////////////////////////
  // local MAC
  ////////////////////////////////////////

  always_comb begin
    if (eeprom_cfg_q[EEPROM_ALT_MAC_BIT]) begin
      local_mac_o = {BASE_MAC[MAC_W-1:16], alt_mac_q};
    end else begin
      // pin selects between two factory addresses
      local_mac_o = {BASE_MAC[MAC_W-1:2], ~alternate_mac_i, BASE_MAC[0]};
    end
  end

  ////////////////////////////////////////
  // register view for readback
  ////////////////////////////////////////

  assign regs_o.static_ip  = static_ip_q;
  assign regs_o.alt_mac    = alt_mac_q;
  assign regs_o.eeprom_cfg = eeprom_cfg_q;
  assign regs_o.mox        = mox_q;
  assign regs_o.pa_en      = pa_en_q;
  assign regs_o.tx_on      = tx_on_q;

endmodule

// File: hdl/cmd_decode.sv
// Command decoder
// Wishbone classic slave that takes one transfer at a time, maps the
// bus address to an opcode and issues a one-cycle request with ack.

module cmd_decode (
  input  logic                  clk_ctrl,
  input  logic                  rst_n_i,
  // Wishbone classic slave
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  hl2_cmd_pkg::cmd_addr_t wb_adr_i,
  input  hl2_cmd_pkg::cmd_word_t wb_dat_i,
  output logic                  wb_ack_o,
  // decoded request
  output hl2_cmd_pkg::cmd_req_t  req_o
);

  import hl2_cfg_pkg::*;
  import hl2_cmd_pkg::*;

  wb_state_e state_q;
  wb_state_e state_d;
  cmd_op_e   op_dec;
  cmd_op_e   op_q;
  logic      we_q;
  cmd_word_t data_q;
  logic      bus_req;

  assign bus_req = wb_cyc_i && wb_stb_i;

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  always_comb begin
    case (wb_adr_i)
      ADDR_TXCTRL:     op_dec = OP_TXCTRL;
      ADDR_STATIC_IP:  op_dec = OP_STATIC_IP;
      ADDR_ALT_MAC:    op_dec = OP_ALT_MAC;
      ADDR_EEPROM_CFG: op_dec = OP_EEPROM_CFG;
      ADDR_VERSION:    op_dec = OP_VERSION;
      ADDR_STATUS:     op_dec = OP_STATUS;
      // anything else is acked and ignored
      default:         op_dec = OP_NOP;
    endcase
  end

  ////////////////////////////////////////
  // bus FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (bus_req) begin
          state_d = ACK;
        end
      end
      // master still holds stb when it sees ack
      ACK: begin
        state_d = bus_req ? WAIT : IDLE;
      end
      WAIT: begin
        if (!bus_req) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_ctrl) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // capture the transfer when it is first seen
  always_ff @(posedge clk_ctrl) begin
    if (state_q == IDLE && bus_req) begin
      we_q   <= wb_we_i;
      op_q   <= op_dec;
      data_q <= wb_dat_i;
    end
  end

  ////////////////////////////////////////
  // outputs
  ////////////////////////////////////////

  // valid and ack share the single ACK cycle
  assign wb_ack_o    = (state_q == ACK);
  assign req_o.valid = (state_q == ACK);
  assign req_o.we    = we_q;
  assign req_o.op    = op_q;
  assign req_o.data  = data_q;

endmodule

// File: hdl/hl2_cmd_pkg.sv
// Command path types
// Opcodes, decoder states and the packed structs that carry a decoded
// request and the register contents between the command blocks.

package hl2_cmd_pkg;

  ////////////////////////////////////////
  // basic words
  ////////////////////////////////////////

  typedef logic [hl2_cfg_pkg::CMD_ADDR_W-1:0] cmd_addr_t;
  typedef logic [hl2_cfg_pkg::CMD_DATA_W-1:0] cmd_word_t;
  typedef logic [hl2_cfg_pkg::MAC_W-1:0]      mac_t;

  ////////////////////////////////////////
  // enums
  ////////////////////////////////////////

  // one opcode per known command address
  typedef enum logic [2:0] {
    OP_NOP        = 3'd0,
    OP_TXCTRL     = 3'd1,
    OP_STATIC_IP  = 3'd2,
    OP_ALT_MAC    = 3'd3,
    OP_EEPROM_CFG = 3'd4,
    OP_VERSION    = 3'd5,
    OP_STATUS     = 3'd6
  } cmd_op_e;

  // Wishbone slave states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    ACK  = 2'd1,
    WAIT = 2'd2
  } wb_state_e;

  ////////////////////////////////////////
  // structs
  ////////////////////////////////////////

  // decoded request, valid for one cycle per transfer
  typedef struct packed {
    logic      valid;
    logic      we;
    cmd_op_e   op;
    cmd_word_t data;
  } cmd_req_t;

  // register contents seen by the readback path
  typedef struct packed {
    cmd_word_t   static_ip;
    logic [15:0] alt_mac;
    logic [7:0]  eeprom_cfg;
    logic        mox;
    logic        pa_en;
    logic        tx_on;
  } cfg_regs_t;

endpackage

// File: hdl/hl2_cfg_pkg.sv
// Command space configuration
// Widths, command addresses and factory defaults shared by the
// Wishbone command decoder, the register block and the readback path.

package hl2_cfg_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  // host command address and data word
  parameter int unsigned CMD_ADDR_W = 6;
  parameter int unsigned CMD_DATA_W = 32;

  // ethernet MAC address
  parameter int unsigned MAC_W = 48;

  ////////////////////////////////////////
  // command addresses
  ////////////////////////////////////////

  // TX control, bit 0 mox, bit 1 PA enable
  parameter logic [CMD_ADDR_W-1:0] ADDR_TXCTRL     = 6'h09;

  // stored network settings
  parameter logic [CMD_ADDR_W-1:0] ADDR_STATIC_IP  = 6'h3b;
  parameter logic [CMD_ADDR_W-1:0] ADDR_ALT_MAC    = 6'h3c;
  parameter logic [CMD_ADDR_W-1:0] ADDR_EEPROM_CFG = 6'h3d;

  // read only words
  parameter logic [CMD_ADDR_W-1:0] ADDR_VERSION    = 6'h3e;
  parameter logic [CMD_ADDR_W-1:0] ADDR_STATUS     = 6'h3f;

  ////////////////////////////////////////
  // EEPROM config and defaults
  ////////////////////////////////////////

  // set means use the stored alternate MAC low half
  parameter int unsigned EEPROM_ALT_MAC_BIT = 6;

  // factory MAC, bit 1 is replaced by the alternate MAC pin
  parameter logic [MAC_W-1:0] DEFAULT_BASE_MAC = 48'h00_1c_c0_a2_13_dd;

endpackage
